// ==== build.f ====
design/axi_router_pkg.sv
design/axi_write_if.sv
design/axi_read_if.sv
design/axi_write_guard.sv
design/axi_read_guard.sv
design/axi_master_1_slave_router.sv
test/axi_router_assertions.sv
test/tb_axi_master_1_slave_router.sv

// ==== design/axi_master_1_slave_router.sv ====
`timescale 1ns/1ps

module axi_master_1_slave_router
  import axi_router_pkg::*;
#(
  parameter int id_width   = 4,
  parameter int data_width = 32
)
(
  input  logic                    axi_master_1_slave_router_clk,
  input  logic                    axi_master_1_slave_router_rstn,

  // Upstream manager side
  input  logic [id_width-1:0]     awid,
  input  addr_t                   awaddr,
  input  len_t                    awlen,
  input  size_t                   awsize,
  input  burst_t                  awburst,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [data_width-1:0]   wdata,
  input  logic [data_width/8-1:0] wstrb,
  input  logic                    wlast,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [id_width-1:0]     bid,
  output resp_t                   bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [id_width-1:0]     arid,
  input  addr_t                   araddr,
  input  len_t                    arlen,
  input  size_t                   arsize,
  input  burst_t                  arburst,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [id_width-1:0]     rid,
  output logic [data_width-1:0]   rdata,
  output resp_t                   rresp,
  output logic                    rlast,
  output logic                    rvalid,
  input  logic                    rready,

  // Downstream interconnect side
  output logic [id_width-1:0]     m1_awid,
  output addr_t                   m1_awaddr,
  output len_t                    m1_awlen,
  output size_t                   m1_awsize,
  output burst_t                  m1_awburst,
  output logic                    m1_awvalid,
  input  logic                    m1_awready,
  output logic [data_width-1:0]   m1_wdata,
  output logic [data_width/8-1:0] m1_wstrb,
  output logic                    m1_wlast,
  output logic                    m1_wvalid,
  input  logic                    m1_wready,
  input  logic [id_width-1:0]     m1_bid,
  input  resp_t                   m1_bresp,
  input  logic                    m1_bvalid,
  output logic                    m1_bready,
  output logic [id_width-1:0]     m1_arid,
  output addr_t                   m1_araddr,
  output len_t                    m1_arlen,
  output size_t                   m1_arsize,
  output burst_t                  m1_arburst,
  output logic                    m1_arvalid,
  input  logic                    m1_arready,
  input  logic [id_width-1:0]     m1_rid,
  input  logic [data_width-1:0]   m1_rdata,
  input  resp_t                   m1_rresp,
  input  logic                    m1_rlast,
  input  logic                    m1_rvalid,
  output logic                    m1_rready
);

  axi_write_if #(.id_width(id_width), .data_width(data_width)) up_wr ();
  axi_write_if #(.id_width(id_width), .data_width(data_width)) dn_wr ();
  axi_read_if  #(.id_width(id_width), .data_width(data_width)) up_rd ();
  axi_read_if  #(.id_width(id_width), .data_width(data_width)) dn_rd ();

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////
  assign {up_wr.awid, up_wr.awaddr, up_wr.awlen, up_wr.awsize, up_wr.awburst, up_wr.awvalid}
    = {awid, awaddr, awlen, awsize, awburst, awvalid};
  assign {up_wr.wdata, up_wr.wstrb, up_wr.wlast, up_wr.wvalid, up_wr.bready}
    = {wdata, wstrb, wlast, wvalid, bready};
  assign {awready, wready, bid, bvalid}
    = {up_wr.awready, up_wr.wready, up_wr.bid, up_wr.bvalid};
  assign bresp = up_wr.bresp;

  assign {m1_awid, m1_awaddr, m1_awlen, m1_awsize, m1_awburst, m1_awvalid}
    = {dn_wr.awid, dn_wr.awaddr, dn_wr.awlen, dn_wr.awsize, dn_wr.awburst, dn_wr.awvalid};
  assign {m1_wdata, m1_wstrb, m1_wlast, m1_wvalid, m1_bready}
    = {dn_wr.wdata, dn_wr.wstrb, dn_wr.wlast, dn_wr.wvalid, dn_wr.bready};
  assign {dn_wr.awready, dn_wr.wready, dn_wr.bid, dn_wr.bvalid}
    = {m1_awready, m1_wready, m1_bid, m1_bvalid};
  assign dn_wr.bresp = m1_bresp;

  axi_write_guard #(.id_width(id_width), .data_width(data_width)) u_write_guard (
    .axi_master_1_slave_router_clk  (axi_master_1_slave_router_clk),
    .axi_master_1_slave_router_rstn (axi_master_1_slave_router_rstn),
    .up                             (up_wr),
    .dn                             (dn_wr)
  );

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////
  assign {up_rd.arid, up_rd.araddr, up_rd.arlen, up_rd.arsize, up_rd.arburst, up_rd.arvalid}
    = {arid, araddr, arlen, arsize, arburst, arvalid};
  assign up_rd.rready = rready;
  assign {arready, rid, rdata, rlast, rvalid}
    = {up_rd.arready, up_rd.rid, up_rd.rdata, up_rd.rlast, up_rd.rvalid};
  assign rresp = up_rd.rresp;

  assign {m1_arid, m1_araddr, m1_arlen, m1_arsize, m1_arburst, m1_arvalid}
    = {dn_rd.arid, dn_rd.araddr, dn_rd.arlen, dn_rd.arsize, dn_rd.arburst, dn_rd.arvalid};
  assign m1_rready = dn_rd.rready;
  assign {dn_rd.arready, dn_rd.rid, dn_rd.rdata, dn_rd.rlast, dn_rd.rvalid}
    = {m1_arready, m1_rid, m1_rdata, m1_rlast, m1_rvalid};
  assign dn_rd.rresp = m1_rresp;

  axi_read_guard #(.id_width(id_width), .data_width(data_width)) u_read_guard (
    .axi_master_1_slave_router_clk  (axi_master_1_slave_router_clk),
    .axi_master_1_slave_router_rstn (axi_master_1_slave_router_rstn),
    .up                             (up_rd),
    .dn                             (dn_rd)
  );

endmodule

// ==== design/axi_read_guard.sv ====
`timescale 1ns/1ps

module axi_read_guard
  import axi_router_pkg::*;
#(
  parameter int id_width   = 4,
  parameter int data_width = 32
)
(
  input  logic            axi_master_1_slave_router_clk,
  input  logic            axi_master_1_slave_router_rstn,
  axi_read_if.subordinate up,
  axi_read_if.manager     dn
);

  rd_state_t           state;
  rd_state_t           state_next;
  logic [id_width-1:0] cap_id;
  len_t                cap_len;
  len_t                beat_cnt;
  logic                ar_allowed;
  logic                pass_ar;
  logic                pass_r;
  logic                err_beat;
  logic                err_last;

  assign ar_allowed = !addr_forbidden(up.araddr);
  assign pass_ar    = (state == rd_idle) && up.arvalid && ar_allowed;
  assign pass_r     = (state == rd_pass_data);
  assign err_beat   = (state == rd_err_data);
  assign err_last   = (beat_cnt == cap_len);

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    unique case (state)
      rd_idle:
      begin
        if (up.arvalid && !ar_allowed)
          state_next = rd_err_addr;
        else if (pass_ar && dn.arready)
          state_next = rd_pass_data;
      end
      rd_pass_data:
      begin
        if (dn.rvalid && up.rready && dn.rlast)
          state_next = rd_idle;
      end
      rd_err_addr:
        state_next = rd_err_data;
      rd_err_data:
      begin
        if (up.rready && err_last)
          state_next = rd_idle;
      end
      default:
        state_next = rd_idle;
    endcase
  end

  always_ff @(posedge axi_master_1_slave_router_clk or negedge axi_master_1_slave_router_rstn)
  begin
    if (!axi_master_1_slave_router_rstn)
    begin
      state    <= rd_idle;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_next;
      if (state == rd_err_addr)
        beat_cnt <= '0;
      else if (err_beat && up.rready)
        beat_cnt <= beat_cnt + 8'd1;
    end
  end

  // Request fields of a blocked read
  always_ff @(posedge axi_master_1_slave_router_clk)
  begin
    if (state == rd_err_addr)
    begin
      cap_id  <= up.arid;
      cap_len <= up.arlen;
    end
  end

  ////////////////////////////////////////
  // Channel steering
  ////////////////////////////////////////
  assign dn.arvalid = pass_ar;
  assign dn.arid    = pass_ar ? up.arid : {id_width{1'b0}};
  assign dn.araddr  = pass_ar ? up.araddr : '0;
  assign dn.arlen   = pass_ar ? up.arlen : '0;
  assign dn.arsize  = pass_ar ? up.arsize : '0;
  assign dn.arburst = pass_ar ? up.arburst : '0;
  assign up.arready = (state == rd_err_addr) || (pass_ar && dn.arready);

  // Error burst has zero data and DECERR on every beat
  assign dn.rready = pass_r && up.rready;
  assign up.rvalid = err_beat || (pass_r && dn.rvalid);
  assign up.rid    = err_beat ? cap_id : dn.rid;
  assign up.rdata  = err_beat ? {data_width{1'b0}} : dn.rdata;
  assign up.rresp  = err_beat ? resp_decerr : dn.rresp;
  assign up.rlast  = err_beat ? err_last : dn.rlast;

endmodule

// ==== design/axi_read_if.sv ====
`timescale 1ns/1ps

interface axi_read_if
  import axi_router_pkg::*;
#(
  parameter int id_width   = 4,
  parameter int data_width = 32
);

  // Read address
  logic [id_width-1:0]   arid;
  addr_t                 araddr;
  len_t                  arlen;
  size_t                 arsize;
  burst_t                arburst;
  logic                  arvalid;
  logic                  arready;

  // Read data
  logic [id_width-1:0]   rid;
  logic [data_width-1:0] rdata;
  resp_t                 rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  rready;

  modport manager (
    output arid, araddr, arlen, arsize, arburst, arvalid,
    input  arready,
    input  rid, rdata, rresp, rlast, rvalid,
    output rready
  );

  modport subordinate (
    input  arid, araddr, arlen, arsize, arburst, arvalid,
    output arready,
    output rid, rdata, rresp, rlast, rvalid,
    input  rready
  );

endinterface

// ==== design/axi_router_pkg.sv ====
package axi_router_pkg;

  ////////////////////////////////////////
  // Field types
  ////////////////////////////////////////
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  ////////////////////////////////////////
  // Guard states
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    wr_idle,
    wr_pass_data,
    wr_pass_resp,
    wr_err_addr,
    wr_err_data,
    wr_err_resp
  } wr_state_t;

  typedef enum logic [2:0] {
    rd_idle,
    rd_pass_data,
    rd_err_addr,
    rd_err_data
  } rd_state_t;

  ////////////////////////////////////////
  // Forbidden windows, inclusive bounds
  ////////////////////////////////////////
  localparam addr_t forbidden_base [0:3] =
    '{32'h0000_0000, 32'h0000_4000, 32'h0000_A000, 32'h0000_C000};
  localparam addr_t forbidden_limit [0:3] =
    '{32'h0000_0FFF, 32'h0000_4FFF, 32'h0000_AFFF, 32'h0000_CFFF};

  function automatic logic addr_forbidden(input addr_t addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      if ((addr >= forbidden_base[i]) && (addr <= forbidden_limit[i]))
      begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

endpackage

// ==== design/axi_write_guard.sv ====
`timescale 1ns/1ps

module axi_write_guard
  import axi_router_pkg::*;
#(
  parameter int id_width   = 4,
  parameter int data_width = 32
)
(
  input  logic             axi_master_1_slave_router_clk,
  input  logic             axi_master_1_slave_router_rstn,
  axi_write_if.subordinate up,
  axi_write_if.manager     dn
);

  localparam int strb_width = data_width / 8;

  wr_state_t           state;
  wr_state_t           state_next;
  logic [id_width-1:0] cap_id;
  logic                aw_allowed;
  logic                pass_aw;
  logic                pass_w;
  logic                pass_b;
  logic                err_resp;

  assign aw_allowed = !addr_forbidden(up.awaddr);
  assign pass_aw    = (state == wr_idle) && up.awvalid && aw_allowed;
  assign pass_w     = (state == wr_pass_data);
  assign pass_b     = (state == wr_pass_resp);
  assign err_resp   = (state == wr_err_resp);

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////
  always_comb
  begin
    state_next = state;
    unique case (state)
      wr_idle:
      begin
        if (up.awvalid && !aw_allowed)
          state_next = wr_err_addr;
        else if (pass_aw && dn.awready)
          state_next = wr_pass_data;
      end
      wr_pass_data:
      begin
        if (up.wvalid && dn.wready && up.wlast)
          state_next = wr_pass_resp;
      end
      wr_pass_resp:
      begin
        if (dn.bvalid && up.bready)
          state_next = wr_idle;
      end
      // AW handshake is certain here since awvalid is held
      wr_err_addr:
        state_next = wr_err_data;
      wr_err_data:
      begin
        if (up.wvalid && up.wlast)
          state_next = wr_err_resp;
      end
      wr_err_resp:
      begin
        if (up.bready)
          state_next = wr_idle;
      end
      default:
        state_next = wr_idle;
    endcase
  end

  always_ff @(posedge axi_master_1_slave_router_clk or negedge axi_master_1_slave_router_rstn)
  begin
    if (!axi_master_1_slave_router_rstn)
      state <= wr_idle;
    else
      state <= state_next;
  end

  always_ff @(posedge axi_master_1_slave_router_clk)
  begin
    if (state == wr_err_addr)
      cap_id <= up.awid;
  end

  ////////////////////////////////////////
  // Channel steering
  ////////////////////////////////////////
  assign dn.awvalid = pass_aw;
  assign dn.awid    = pass_aw ? up.awid : {id_width{1'b0}};
  assign dn.awaddr  = pass_aw ? up.awaddr : '0;
  assign dn.awlen   = pass_aw ? up.awlen : '0;
  assign dn.awsize  = pass_aw ? up.awsize : '0;
  assign dn.awburst = pass_aw ? up.awburst : '0;
  assign up.awready = (state == wr_err_addr) || (pass_aw && dn.awready);

  // Blocked beats are swallowed here, wlast alone ends the burst
  assign dn.wvalid = pass_w && up.wvalid;
  assign dn.wdata  = pass_w ? up.wdata : {data_width{1'b0}};
  assign dn.wstrb  = pass_w ? up.wstrb : {strb_width{1'b0}};
  assign dn.wlast  = pass_w && up.wlast;
  assign up.wready = (state == wr_err_data) || (pass_w && dn.wready);

  assign dn.bready = pass_b && up.bready;
  assign up.bvalid = err_resp || (pass_b && dn.bvalid);
  assign up.bid    = err_resp ? cap_id : dn.bid;
  assign up.bresp  = err_resp ? resp_decerr : dn.bresp;

endmodule

// ==== design/axi_write_if.sv ====
`timescale 1ns/1ps

interface axi_write_if
  import axi_router_pkg::*;
#(
  parameter int id_width   = 4,
  parameter int data_width = 32
);

  localparam int strb_width = data_width / 8;

  // Write address
  logic [id_width-1:0]   awid;
  addr_t                 awaddr;
  len_t                  awlen;
  size_t                 awsize;
  burst_t                awburst;
  logic                  awvalid;
  logic                  awready;

  // Write data
  logic [data_width-1:0] wdata;
  logic [strb_width-1:0] wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;

  // Write response
  logic [id_width-1:0]   bid;
  resp_t                 bresp;
  logic                  bvalid;
  logic                  bready;

  modport manager (
    output awid, awaddr, awlen, awsize, awburst, awvalid,
    input  awready,
    output wdata, wstrb, wlast, wvalid,
    input  wready,
    input  bid, bresp, bvalid,
    output bready
  );

  modport subordinate (
    input  awid, awaddr, awlen, awsize, awburst, awvalid,
    output awready,
    input  wdata, wstrb, wlast, wvalid,
    output wready,
    output bid, bresp, bvalid,
    input  bready
  );

endinterface

// ==== test/axi_router_assertions.sv ====
`timescale 1ns/1ps

module axi_router_assertions
  import axi_router_pkg::*;
#(
  parameter int payload_width = 8,
  parameter int data_width    = 32,
  parameter bit has_data      = 1'b1
)
(
  input logic                     axi_master_1_slave_router_clk,
  input logic                     axi_master_1_slave_router_rstn,
  input logic                     fwd_valid,
  input addr_t                    fwd_addr,
  input logic                     local_valid,
  input logic                     local_ready,
  input logic [payload_width-1:0] local_payload,
  input logic [data_width-1:0]    local_data
);

  // Forbidden 4 KB pages
  function automatic logic page_blocked(input addr_t addr);
    return (addr[31:12] == 20'h0) || (addr[31:12] == 20'h4) ||
           (addr[31:12] == 20'hA) || (addr[31:12] == 20'hC);
  endfunction

  no_blocked_forward: assert property (
    @(posedge axi_master_1_slave_router_clk) disable iff (!axi_master_1_slave_router_rstn)
    fwd_valid |-> !page_blocked(fwd_addr))
  else $error("Downstream valid raised for forbidden address %h", fwd_addr);

  local_held: assert property (
    @(posedge axi_master_1_slave_router_clk) disable iff (!axi_master_1_slave_router_rstn)
    (local_valid && !local_ready) |=> (local_valid && $stable(local_payload)))
  else $error("Local response changed before ready");

  // Only a channel with a data bus has zero error data
  if (has_data)
  begin : g_zero_data
    local_zero_data: assert property (
      @(posedge axi_master_1_slave_router_clk) disable iff (!axi_master_1_slave_router_rstn)
      local_valid |-> (local_data == '0))
    else $error("Error response carries nonzero data %h", local_data);
  end

endmodule

bind axi_write_guard axi_router_assertions #(
  .payload_width (id_width + 2),
  .data_width    (data_width),
  .has_data      (1'b0)
) u_write_assertions (
  .axi_master_1_slave_router_clk  (axi_master_1_slave_router_clk),
  .axi_master_1_slave_router_rstn (axi_master_1_slave_router_rstn),
  .fwd_valid                      (dn.awvalid),
  .fwd_addr                       (dn.awaddr),
  .local_valid                    (err_resp),
  .local_ready                    (up.bready),
  .local_payload                  ({up.bid, up.bresp}),
  .local_data                     ({data_width{1'b0}})
);

bind axi_read_guard axi_router_assertions #(
  .payload_width (id_width + data_width + 3),
  .data_width    (data_width),
  .has_data      (1'b1)
) u_read_assertions (
  .axi_master_1_slave_router_clk  (axi_master_1_slave_router_clk),
  .axi_master_1_slave_router_rstn (axi_master_1_slave_router_rstn),
  .fwd_valid                      (dn.arvalid),
  .fwd_addr                       (dn.araddr),
  .local_valid                    (err_beat),
  .local_ready                    (up.rready),
  .local_payload                  ({up.rid, up.rdata, up.rresp, up.rlast}),
  .local_data                     (up.rdata)
);

// ==== test/tb_axi_master_1_slave_router.sv ====
`timescale 1ns/1ps

module tb_axi_master_1_slave_router
  import axi_router_pkg::*;
();

  localparam int id_width    = 4;
  localparam int data_width  = 32;
  localparam int cycle_limit = 20000;
  localparam addr_t win_base [0:3] = '{32'h0000_0000, 32'h0000_4000, 32'h0000_A000, 32'h0000_C000};

  logic axi_master_1_slave_router_clk;
  logic axi_master_1_slave_router_rstn;

  logic [id_width-1:0]     awid, bid, arid, rid;
  addr_t                   awaddr, araddr;
  len_t                    awlen, arlen;
  size_t                   awsize, arsize;
  burst_t                  awburst, arburst;
  logic                    awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic                    arvalid, arready, rlast, rvalid, rready;
  logic [data_width-1:0]   wdata, rdata;
  logic [data_width/8-1:0] wstrb;
  resp_t                   bresp, rresp;

  logic [id_width-1:0]     m1_awid, m1_bid, m1_arid, m1_rid;
  addr_t                   m1_awaddr, m1_araddr;
  len_t                    m1_awlen, m1_arlen;
  size_t                   m1_awsize, m1_arsize;
  burst_t                  m1_awburst, m1_arburst;
  logic                    m1_awvalid, m1_awready, m1_wlast, m1_wvalid, m1_wready;
  logic                    m1_bvalid, m1_bready, m1_arvalid, m1_arready;
  logic                    m1_rlast, m1_rvalid, m1_rready;
  logic [data_width-1:0]   m1_wdata, m1_rdata;
  logic [data_width/8-1:0] m1_wstrb;
  resp_t                   m1_bresp, m1_rresp;

  // Interconnect model state
  logic [id_width-1:0]   dn_aw_id [$];
  addr_t                 dn_aw_addr [$];
  len_t                  dn_aw_len [$];
  size_t                 dn_aw_size [$];
  burst_t                dn_aw_burst [$];
  logic [data_width-1:0] dn_w_data [$];
  logic [data_width/8-1:0] dn_w_strb [$];
  logic                  dn_w_last [$];
  size_t                 dn_ar_size [$];
  burst_t                dn_ar_burst [$];
  logic [id_width-1:0]   b_pend [$];
  logic [id_width-1:0]   wr_cur_id;
  logic [id_width-1:0]   rq_id [$];
  addr_t                 rq_addr [$];
  len_t                  rq_len [$];
  logic                  r_active = 1'b0;
  logic [id_width-1:0]   r_id;
  addr_t                 r_addr;
  len_t                  r_len;
  int                    r_beat = 0;

  logic [31:0] rng = 32'd65930;
  logic        stall_up = 1'b0;
  int aw_count = 0;
  int w_count = 0;
  int ar_count = 0;
  int b_seen = 0;
  int r_seen = 0;
  int writes_issued = 0;
  int beats_expected = 0;
  int checks = 0;
  int errors = 0;
  int cycles = 0;

  axi_master_1_slave_router #(.id_width(id_width), .data_width(data_width)) UUT (.*);

  initial
  begin
    axi_master_1_slave_router_clk = 1'b0;
    forever #50 axi_master_1_slave_router_clk = ~axi_master_1_slave_router_clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Ready is high three cycles in four when stalling
  function automatic logic ready_draw(input logic stall);
    if (!stall)
      return 1'b1;
    return (next_rand() & 32'd3) != 0;
  endfunction

  function automatic logic in_window(input addr_t a);
    return (a[31:12] == 20'h0) || (a[31:12] == 20'h4) || (a[31:12] == 20'hA) ||
           (a[31:12] == 20'hC);
  endfunction

  function automatic addr_t allowed_addr();
    addr_t a;
    do
      a = next_rand() & 32'h0001_FFFC;
    while (in_window(a));
    return a;
  endfunction

  function automatic addr_t blocked_addr(input int w);
    return win_base[w] | (next_rand() & 32'h0000_0FFC);
  endfunction

  function automatic len_t rand_len();
    return len_t'(next_rand() % 8);
  endfunction

  function automatic logic [id_width-1:0] rand_id();
    return id_width'(next_rand());
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_resp(input resp_t got, input resp_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_id(input logic [id_width-1:0] got, input logic [id_width-1:0] exp,
                          input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input logic [data_width-1:0] got, input logic [data_width-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Interconnect model
  ////////////////////////////////////////
  always @(posedge axi_master_1_slave_router_clk)
  begin
    if (axi_master_1_slave_router_rstn)
    begin
      if (m1_awvalid && m1_awready)
      begin
        dn_aw_id.push_back(m1_awid);
        dn_aw_addr.push_back(m1_awaddr);
        dn_aw_len.push_back(m1_awlen);
        dn_aw_size.push_back(m1_awsize);
        dn_aw_burst.push_back(m1_awburst);
        wr_cur_id = m1_awid;
        aw_count++;
      end
      if (m1_wvalid && m1_wready)
      begin
        dn_w_data.push_back(m1_wdata);
        dn_w_strb.push_back(m1_wstrb);
        dn_w_last.push_back(m1_wlast);
        w_count++;
        if (m1_wlast)
          b_pend.push_back(wr_cur_id);
      end
      if (m1_bvalid && m1_bready)
        m1_bvalid <= 1'b0;
      else if (!m1_bvalid && (b_pend.size() > 0))
      begin
        m1_bvalid <= 1'b1;
        m1_bid    <= b_pend.pop_front();
        m1_bresp  <= resp_okay;
      end
      m1_awready <= ready_draw(1'b1);
      m1_wready  <= ready_draw(1'b1);
    end
  end

  // Read beats carry the address plus the beat index
  always @(posedge axi_master_1_slave_router_clk)
  begin
    if (axi_master_1_slave_router_rstn)
    begin
      if (m1_arvalid && m1_arready)
      begin
        rq_id.push_back(m1_arid);
        rq_addr.push_back(m1_araddr);
        rq_len.push_back(m1_arlen);
        dn_ar_size.push_back(m1_arsize);
        dn_ar_burst.push_back(m1_arburst);
        ar_count++;
      end
      if (m1_rvalid && m1_rready)
      begin
        if (r_beat == r_len)
          r_active = 1'b0;
        else
          r_beat++;
      end
      if (!r_active && (rq_id.size() > 0))
      begin
        r_id     = rq_id.pop_front();
        r_addr   = rq_addr.pop_front();
        r_len    = rq_len.pop_front();
        r_beat   = 0;
        r_active = 1'b1;
      end
      if (!r_active)
        m1_rvalid <= 1'b0;
      else if (!m1_rvalid || m1_rready)
      begin
        m1_rvalid <= 1'b1;
        m1_rid    <= r_id;
        m1_rdata  <= r_addr + r_beat;
        m1_rresp  <= resp_okay;
        m1_rlast  <= (r_beat == r_len);
      end
      m1_arready <= ready_draw(1'b1);
    end
  end

  // Upstream handshake counts and the run limit
  always @(posedge axi_master_1_slave_router_clk)
  begin
    if (bvalid && bready)
      b_seen++;
    if (rvalid && rready)
      r_seen++;
    cycles++;
    if (cycles >= cycle_limit)
    begin
      errors++;
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Upstream transactions
  ////////////////////////////////////////
  task automatic do_write(input addr_t addr, input len_t len, input logic [id_width-1:0] id);
    logic                  blocked;
    int                    aw_before;
    int                    w_before;
    logic [data_width-1:0] beats [$];
    resp_t                 got_resp;
    logic [id_width-1:0]   got_id;
    blocked   = in_window(addr);
    aw_before = aw_count;
    w_before  = w_count;
    writes_issued++;
    for (int i = 0; i <= len; i++)
      beats.push_back(next_rand());
    fork
      begin
        awvalid <= 1'b1;
        awid    <= id;
        awaddr  <= addr;
        awlen   <= len;
        awsize  <= 3'd2;
        awburst <= 2'b01;
        do @(posedge axi_master_1_slave_router_clk); while (!(awvalid && awready));
        awvalid <= 1'b0;
      end
      begin
        for (int i = 0; i <= len; i++)
        begin
          wvalid <= 1'b1;
          wdata  <= beats[i];
          wstrb  <= '1;
          wlast  <= (i == len);
          do @(posedge axi_master_1_slave_router_clk); while (!(wvalid && wready));
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
      end
      begin
        do
        begin
          bready <= ready_draw(stall_up);
          @(posedge axi_master_1_slave_router_clk);
        end
        while (!(bvalid && bready));
        got_resp = bresp;
        got_id   = bid;
        bready <= 1'b0;
      end
    join
    check_id(got_id, id, "bid");
    check_resp(got_resp, blocked ? resp_decerr : resp_okay, "bresp");
    if (blocked)
    begin
      check_bit(aw_count == aw_before, 1'b1, "no downstream AW for blocked write");
      check_bit(w_count == w_before, 1'b1, "no downstream W for blocked write");
    end
    else
    begin
      check_bit(aw_count == aw_before + 1, 1'b1, "downstream AW count");
      check_bit(w_count == w_before + len + 1, 1'b1, "downstream W beat count");
      if (dn_aw_id.size() > 0)
      begin
        check_id(dn_aw_id.pop_front(), id, "m1_awid");
        check_addr(dn_aw_addr.pop_front(), addr, "m1_awaddr");
        check_bit(dn_aw_len.pop_front() == len, 1'b1, "m1_awlen");
        check_bit(dn_aw_size.pop_front() == 3'd2, 1'b1, "m1_awsize");
        check_bit(dn_aw_burst.pop_front() == 2'b01, 1'b1, "m1_awburst");
      end
      foreach (beats[i])
      begin
        if (dn_w_data.size() > 0)
        begin
          check_data(dn_w_data.pop_front(), beats[i], "m1_wdata");
          check_bit(dn_w_strb.pop_front() == '1, 1'b1, "m1_wstrb");
          check_bit(dn_w_last.pop_front(), (i == len), "m1_wlast");
        end
      end
    end
  endtask

  task automatic do_read(input addr_t addr, input len_t len, input logic [id_width-1:0] id);
    logic blocked;
    int   ar_before;
    blocked   = in_window(addr);
    ar_before = ar_count;
    beats_expected += len + 1;
    fork
      begin
        arvalid <= 1'b1;
        arid    <= id;
        araddr  <= addr;
        arlen   <= len;
        arsize  <= 3'd2;
        arburst <= 2'b01;
        do @(posedge axi_master_1_slave_router_clk); while (!(arvalid && arready));
        arvalid <= 1'b0;
      end
      begin
        for (int i = 0; i <= len; i++)
        begin
          do
          begin
            rready <= ready_draw(stall_up);
            @(posedge axi_master_1_slave_router_clk);
          end
          while (!(rvalid && rready));
          check_id(rid, id, "rid");
          check_data(rdata, blocked ? '0 : addr + i, "rdata");
          check_resp(rresp, blocked ? resp_decerr : resp_okay, "rresp");
          check_bit(rlast, (i == len), "rlast");
        end
        rready <= 1'b0;
      end
    join
    check_bit(ar_count == ar_before + (blocked ? 0 : 1), 1'b1, "downstream AR count");
    if (!blocked && (dn_ar_size.size() > 0))
    begin
      check_bit(dn_ar_size.pop_front() == 3'd2, 1'b1, "m1_arsize");
      check_bit(dn_ar_burst.pop_front() == 2'b01, 1'b1, "m1_arburst");
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic reset_values_test();
    check_bit(awready, 1'b0, "awready after reset");
    check_bit(wready, 1'b0, "wready after reset");
    check_bit(bvalid, 1'b0, "bvalid after reset");
    check_bit(arready, 1'b0, "arready after reset");
    check_bit(rvalid, 1'b0, "rvalid after reset");
    check_bit(m1_awvalid, 1'b0, "m1_awvalid after reset");
    check_bit(m1_wvalid, 1'b0, "m1_wvalid after reset");
    check_bit(m1_bready, 1'b0, "m1_bready after reset");
    check_bit(m1_arvalid, 1'b0, "m1_arvalid after reset");
    check_bit(m1_rready, 1'b0, "m1_rready after reset");
  endtask

  task automatic allowed_write_test();
    do_write(32'h0000_1000, rand_len(), rand_id());
    for (int i = 0; i < 3; i++)
      do_write(allowed_addr(), rand_len(), rand_id());
  endtask

  task automatic blocked_write_test();
    for (int w = 0; w < 4; w++)
      do_write(blocked_addr(w), rand_len(), rand_id());
  endtask

  task automatic allowed_read_test();
    do_read(32'h0000_5000, rand_len(), rand_id());
    for (int i = 0; i < 3; i++)
      do_read(allowed_addr(), rand_len(), rand_id());
  endtask

  task automatic blocked_read_test();
    for (int w = 0; w < 4; w++)
      do_read(blocked_addr(w), rand_len(), rand_id());
  endtask

  // Writes and reads run side by side under upstream stalls
  task automatic mixed_traffic_test();
    stall_up = 1'b1;
    fork
      for (int i = 0; i < 8; i++)
        do_write((i % 2) ? blocked_addr(i % 4) : allowed_addr(), rand_len(), rand_id());
      for (int i = 0; i < 8; i++)
        do_read((i % 2) ? allowed_addr() : blocked_addr(i % 4), rand_len(), rand_id());
    join
    stall_up = 1'b0;
  endtask

  initial
  begin
    axi_master_1_slave_router_rstn <= 1'b0;
    {awid, awaddr, awlen, awsize, awburst, awvalid} <= '0;
    {wdata, wstrb, wlast, wvalid, bready} <= '0;
    {arid, araddr, arlen, arsize, arburst, arvalid, rready} <= '0;
    {m1_awready, m1_wready, m1_bid, m1_bvalid, m1_arready} <= '0;
    {m1_rid, m1_rdata, m1_rlast, m1_rvalid} <= '0;
    m1_bresp <= resp_okay;
    m1_rresp <= resp_okay;
    repeat (10) @(posedge axi_master_1_slave_router_clk);
    axi_master_1_slave_router_rstn <= 1'b1;
    @(posedge axi_master_1_slave_router_clk);
    reset_values_test();
    allowed_write_test();
    blocked_write_test();
    allowed_read_test();
    blocked_read_test();
    mixed_traffic_test();
    repeat (20) @(posedge axi_master_1_slave_router_clk);
    check_bit(b_seen == writes_issued, 1'b1, "upstream B response count");
    check_bit(r_seen == beats_expected, 1'b1, "upstream R beat count");
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
